/* tenyrPkg.sv */
package tenyrPkg;

    typedef logic [31:0] word_t;   // Data and address word
    typedef logic [3:0]  regIdx_t;

    typedef enum logic [3:0] {
        OP_OR    = 4'd0,
        OP_AND   = 4'd1,
        OP_ADD   = 4'd2,
        OP_MUL   = 4'd3,
        OP_RSV4  = 4'd4,   // Reserved
        OP_SHL   = 4'd5,
        OP_LT    = 4'd6,
        OP_EQ    = 4'd7,
        OP_GT    = 4'd8,
        OP_ANDN  = 4'd9,
        OP_XOR   = 4'd10,
        OP_SUB   = 4'd11,
        OP_XNOR  = 4'd12,
        OP_SHR   = 4'd13,
        OP_NE    = 4'd14,
        OP_RSV15 = 4'd15   // Reserved
    } aluOp_e;

    typedef enum logic [1:0] {
        PH_FETCH = 2'd0,
        PH_EXEC  = 2'd1,
        PH_WRITE = 2'd2
    } phase_e;

    // Index that reads as the program counter plus one
    localparam regIdx_t PC_INDEX = 4'd15;

    // Instruction word layout
    localparam int TYPE_BIT  = 30;
    localparam int STORE_BIT = 29;
    localparam int DEREF_BIT = 28;
    localparam int Z_LSB     = 24;
    localparam int X_LSB     = 20;
    localparam int Y_LSB     = 16;
    localparam int OP_LSB    = 12;
    localparam int IMM_WIDTH = 12;   // Low bits, sign-extended

endpackage

/* decodeIf.sv */
`timescale 1ns/1ps

interface decodeIf;
    import tenyrPkg::*;

    regIdx_t indexZ;     // Destination, or store operand
    regIdx_t indexX;
    regIdx_t indexY;
    aluOp_e  op;
    word_t   imm;        // Already sign-extended
    logic    immType;    // Immediate takes the Y operand slot
    logic    storing;
    logic    derefRhs;   // Right-hand side goes through memory
    logic    branch;     // Result lands in the program counter
    logic    illegal;

    modport producer (
        output indexZ, indexX, indexY,
        output op, imm,
        output immType, storing, derefRhs, branch, illegal
    );

    modport consumer (
        input indexZ, indexX, indexY,
        input op, imm,
        input immType, storing, derefRhs, branch, illegal
    );

endinterface

/* insnDecoder.sv */
`timescale 1ns/1ps

module insnDecoder (
    input  tenyrPkg::word_t insn,
    decodeIf.producer       dec
);
    import tenyrPkg::*;

    localparam int IDX_W  = $bits(regIdx_t);
    localparam int WORD_W = $bits(word_t);

    logic [IMM_WIDTH-1:0] immField;
    regIdx_t              fieldZ;

    // Flag bits
    assign dec.immType  = insn[TYPE_BIT];
    assign dec.storing  = insn[STORE_BIT];
    assign dec.derefRhs = insn[DEREF_BIT];

    // Register indices and opcode
    assign fieldZ       = insn[Z_LSB +: IDX_W];
    assign dec.indexZ   = fieldZ;
    assign dec.indexX   = insn[X_LSB +: IDX_W];
    assign dec.indexY   = insn[Y_LSB +: IDX_W];
    assign dec.op       = aluOp_e'(insn[OP_LSB +: 4]);

    // Immediate with its top bit copied upward
    assign immField     = insn[IMM_WIDTH-1:0];
    assign dec.imm      = {{(WORD_W - IMM_WIDTH){immField[IMM_WIDTH-1]}}, immField};

    assign dec.illegal  = &insn;   // All-ones word stops the core
    assign dec.branch   = (fieldZ == PC_INDEX) && !insn[STORE_BIT];

endmodule

/* aluExecutor.sv */
`timescale 1ns/1ps

module aluExecutor (
    input  logic            clk,
    input  logic            reset_n,
    input  logic            load,
    decodeIf.consumer       dec,
    input  tenyrPkg::word_t valueX,
    input  tenyrPkg::word_t valueY,
    output tenyrPkg::word_t rhs
);
    import tenyrPkg::*;

    word_t operand;
    word_t addend;
    word_t opResult;
    logic  bigShift;

    // Immediate and Y swap roles with the type bit
    assign operand  = dec.immType ? dec.imm : valueY;
    assign addend   = dec.immType ? valueY : dec.imm;
    assign bigShift = |operand[31:5];   // Amount of 32 or more

    always_comb begin
        case (dec.op)
            OP_OR:   opResult = valueX | operand;
            OP_AND:  opResult = valueX & operand;
            OP_ADD:  opResult = valueX + operand;
            OP_MUL:  opResult = valueX * operand;   // Low 32 bits
            OP_SHL:  opResult = bigShift ? '0 : valueX << operand[4:0];
            OP_LT:   opResult = {32{$signed(valueX) < $signed(operand)}};
            OP_EQ:   opResult = {32{valueX == operand}};
            OP_GT:   opResult = {32{$signed(valueX) > $signed(operand)}};
            OP_ANDN: opResult = valueX & ~operand;
            OP_XOR:  opResult = valueX ^ operand;
            OP_SUB:  opResult = valueX - operand;
            OP_XNOR: opResult = valueX ^ ~operand;
            OP_SHR:  opResult = bigShift ? '0 : valueX >> operand[4:0];
            OP_NE:   opResult = {32{valueX != operand}};
            default: opResult = '0;   // OP_RSV4 and OP_RSV15
        endcase
    end

    // Captured at the edge that ends EXEC
    always_ff @(posedge clk) begin
        if (!reset_n) begin
            rhs <= '0;
        end else if (load) begin
            rhs <= opResult + addend;
        end
    end

endmodule

/* regFile.sv */
`timescale 1ns/1ps

module regFile (
    input  logic            clk,
    input  logic            reset_n,
    input  logic            writeEn,
    input  tenyrPkg::word_t pc,
    input  tenyrPkg::word_t writeData,
    decodeIf.consumer       dec,
    output tenyrPkg::word_t valueZ,
    output tenyrPkg::word_t valueX,
    output tenyrPkg::word_t valueY
);
    import tenyrPkg::*;

    word_t regs [1:14];   // r0 and r15 have no storage
    logic  writable;

    function automatic word_t readReg(regIdx_t idx);
        word_t value;
        if (idx == '0) begin
            value = '0;
        end else if (idx == PC_INDEX) begin
            value = pc + 1;   // Address of the next instruction
        end else begin
            value = regs[idx];
        end
        return value;
    endfunction

    always_comb begin
        valueZ = readReg(dec.indexZ);
        valueX = readReg(dec.indexX);
        valueY = readReg(dec.indexY);
    end

    assign writable = (dec.indexZ != '0) && (dec.indexZ != PC_INDEX);

    always_ff @(posedge clk) begin
        if (!reset_n) begin
            for (int i = 1; i <= 14; i++) begin
                regs[i] <= '0;
            end
        end else if (writeEn && writable) begin
            regs[dec.indexZ] <= writeData;
        end
    end

endmodule

/* tenyrCore.sv */
`timescale 1ns/1ps

module tenyrCore #(
    parameter tenyrPkg::word_t RESET_VECTOR = '0
) (
    input  logic            clk,
    input  logic            reset_n,
    input  logic            enable,
    input  tenyrPkg::word_t iData,
    input  tenyrPkg::word_t dDataIn,
    output tenyrPkg::word_t iAddr,
    output tenyrPkg::word_t dAddr,
    output tenyrPkg::word_t dDataOut,
    output logic            dWrite,
    output logic            halt
);
    import tenyrPkg::*;

    phase_e phase;
    logic   run;
    logic   execLoad;
    logic   regWrite;
    logic   loading;
    word_t  valueZ;
    word_t  valueX;
    word_t  valueY;
    word_t  execRhs;
    word_t  rhsValue;

    decodeIf dec ();

    // Decode runs straight off the fetched word
    insnDecoder decoder (
        .insn (iData),
        .dec  (dec)
    );

    aluExecutor executor (
        .clk     (clk),
        .reset_n (reset_n),
        .load    (execLoad),
        .dec     (dec),
        .valueX  (valueX),
        .valueY  (valueY),
        .rhs     (execRhs)
    );

    regFile registers (
        .clk       (clk),
        .reset_n   (reset_n),
        .writeEn   (regWrite),
        .pc        (iAddr),
        .writeData (rhsValue),
        .dec       (dec),
        .valueZ    (valueZ),
        .valueX    (valueX),
        .valueY    (valueY)
    );

    assign run      = enable && !halt;   // A halted core never advances
    assign execLoad = run && (phase == PH_EXEC);
    assign regWrite = run && (phase == PH_WRITE) && !dec.storing;

    // Load result comes back from data memory
    assign loading  = dec.derefRhs && !dec.storing;
    assign rhsValue = loading ? dDataIn : execRhs;

    // Deref selects which side is the address
    assign dAddr    = dec.derefRhs ? execRhs : valueZ;
    assign dDataOut = dec.derefRhs ? valueZ : execRhs;
    assign dWrite   = run && (phase == PH_WRITE) && dec.storing;

    always_ff @(posedge clk) begin
        if (!reset_n) begin
            phase <= PH_FETCH;
            iAddr <= RESET_VECTOR;
            halt  <= 1'b0;
        end else if (run) begin
            case (phase)
                PH_FETCH: begin
                    phase <= PH_EXEC;
                end
                PH_EXEC: begin
                    phase <= PH_WRITE;
                    halt  <= dec.illegal;   // Blocks the following WRITE
                end
                PH_WRITE: begin
                    phase <= PH_FETCH;
                    iAddr <= dec.branch ? rhsValue : iAddr + 1;
                end
                default: begin
                    phase <= PH_FETCH;
                end
            endcase
        end
    end

endmodule

/* tbClock.sv */
`timescale 1ns/1ps

module tbClock (
    output logic clk,
    output logic reset_n
);

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;   // 4 ns period
    end

    initial begin
        reset_n = 1'b0;
        repeat (16) @(posedge clk);
        @(negedge clk);
        reset_n <= 1'b1;   // Released on a falling edge
    end

endmodule

/* tenyrCore_chk.sv */
`timescale 1ns/1ps

module tenyrCore_chk (
    input logic             clk,
    input logic             reset_n,
    input logic             dWrite,
    input tenyrPkg::phase_e phase,
    input tenyrPkg::word_t  iAddr
);
    import tenyrPkg::*;

    // Store strobe covers exactly one WRITE cycle, then the next fetch begins
    assert property (@(posedge clk) disable iff (!reset_n)
        dWrite |-> phase == PH_WRITE ##1 (phase == PH_FETCH && !dWrite))
        else $error("dWrite not confined to a single PH_WRITE cycle");

    // Each phase either holds or moves to its successor
    assert property (@(posedge clk) disable iff (!reset_n)
        phase == PH_FETCH |=> phase inside {PH_FETCH, PH_EXEC})
        else $error("Phase left FETCH for a state other than EXEC");
    assert property (@(posedge clk) disable iff (!reset_n)
        phase == PH_EXEC |=> phase inside {PH_EXEC, PH_WRITE})
        else $error("Phase left EXEC for a state other than WRITE");
    assert property (@(posedge clk) disable iff (!reset_n)
        phase == PH_WRITE |=> phase inside {PH_WRITE, PH_FETCH})
        else $error("Phase left WRITE for a state other than FETCH");

    assert property (@(posedge clk) disable iff (!reset_n) phase != PH_WRITE |=> $stable(iAddr))
        else $error("iAddr changed outside PH_WRITE");

endmodule

bind tenyrCore tenyrCore_chk chk (
    .clk     (clk),
    .reset_n (reset_n),
    .dWrite  (dWrite),
    .phase   (phase),
    .iAddr   (iAddr)
);

/* tenyrCore_tb.sv */
`timescale 1ns/1ps

module tenyrCore_tb;
    import tenyrPkg::*;

    localparam int          RESET_LIMIT   = 64;
    localparam int          RUN_LIMIT     = 2000;
    localparam logic [11:0] STORE_ADDR    = 12'h0F0;   // Fixed result slot
    localparam word_t       ILLEGAL       = 32'hFFFF_FFFF;
    localparam int          MODE_RANDOM   = 0;
    localparam int          MODE_ZERO     = 1;
    localparam int          MODE_NEG      = 2;
    localparam int          MODE_BIGSHIFT = 3;
    localparam int          MODE_EQUAL    = 4;

    logic  clk;
    logic  reset_n;
    logic  enable;
    logic  dWrite;
    logic  halt;
    word_t iData;
    word_t dDataIn;
    word_t iAddr;
    word_t dAddr;
    word_t dDataOut;

    word_t       imem [0:255];
    word_t       dmem [0:255];
    word_t       lcgState = 32'h739b_0c1d;
    string       rowName [$];
    aluOp_e      rowOp [$];
    logic [11:0] rowImm [$];
    int          rowMode [$];
    string       expName [$];
    word_t       expAddr [$];
    word_t       expData [$];
    int          progLen = 0;
    int          errors = 0;
    int          checkCount = 0;
    int          enabledCycles = 0;
    int          pauseLeft = 0;
    int          waitCount;
    bit          pauseDone = 0;
    word_t       lastAddr;
    word_t       pauseAddr;
    word_t       haltAddr;

    tbClock clockGen (.clk(clk), .reset_n(reset_n));

    tenyrCore #(.RESET_VECTOR(32'h0)) uut (
        .clk(clk), .reset_n(reset_n), .enable(enable), .iData(iData), .dDataIn(dDataIn),
        .iAddr(iAddr), .dAddr(dAddr), .dDataOut(dDataOut), .dWrite(dWrite), .halt(halt)
    );

    assign iData   = imem[iAddr[7:0]];   // Asynchronous memory models
    assign dDataIn = dmem[dAddr[7:0]];

    task automatic checkWord(input string name, input word_t expected, input word_t actual);
        checkCount++;
        if (actual !== expected) begin
            errors++;
            $display("CHECK FAILED %s: expected %h, actual %h", name, expected, actual);
        end
    endtask

    task automatic checkAddr(input string name, input word_t expected, input word_t actual);
        checkCount++;
        if (actual !== expected) begin
            errors++;
            $display("CHECK FAILED %s: expected address %h, actual %h", name, expected, actual);
        end
    endtask

    task automatic checkHalt(input string name, input logic expected, input logic actual);
        checkCount++;
        if (actual !== expected) begin
            errors++;
            $display("CHECK FAILED %s: expected halt %b, actual %b", name, expected, actual);
        end
    endtask

    function automatic word_t nextRand();
        lcgState = lcgState * 32'd1664525 + 32'd1013904223;
        return lcgState;
    endfunction

    function automatic word_t encode(logic typeBit, logic storeBit, logic derefBit, regIdx_t z,
                                     regIdx_t x, regIdx_t y, aluOp_e op, logic [11:0] imm);
        word_t w;
        w = '0;
        w[TYPE_BIT]       = typeBit;
        w[STORE_BIT]      = storeBit;
        w[DEREF_BIT]      = derefBit;
        w[Z_LSB +: 4]     = z;
        w[X_LSB +: 4]     = x;
        w[Y_LSB +: 4]     = y;
        w[OP_LSB +: 4]    = op;
        w[IMM_WIDTH-1:0]  = imm;
        return w;
    endfunction

    // Expected right-hand value for the type bit and opcode rules
    function automatic word_t modelRhs(aluOp_e op, logic typeBit, word_t x, word_t y,
                                       logic [11:0] imm);
        word_t immExt;
        word_t second;
        word_t res;
        immExt = {{20{imm[11]}}, imm};
        second = typeBit ? immExt : y;
        case (op)
            OP_OR:   res = x | second;
            OP_AND:  res = x & second;
            OP_ADD:  res = x + second;
            OP_MUL:  res = x * second;
            OP_SHL:  res = (second > 31) ? 32'h0 : (x << second);
            OP_LT:   res = ($signed(x) < $signed(second)) ? 32'hFFFF_FFFF : 32'h0;
            OP_EQ:   res = (x == second) ? 32'hFFFF_FFFF : 32'h0;
            OP_GT:   res = ($signed(x) > $signed(second)) ? 32'hFFFF_FFFF : 32'h0;
            OP_ANDN: res = x & ~second;
            OP_XOR:  res = x ^ second;
            OP_SUB:  res = x - second;
            OP_XNOR: res = ~(x ^ second);
            OP_SHR:  res = (second > 31) ? 32'h0 : (x >> second);
            OP_NE:   res = (x != second) ? 32'hFFFF_FFFF : 32'h0;
            default: res = 32'h0;   // Reserved codes
        endcase
        return res + (typeBit ? y : immExt);
    endfunction

    task automatic addRow(input string name, input aluOp_e op, input logic [11:0] imm,
                          input int mode);
        rowName.push_back(name);
        rowOp.push_back(op);
        rowImm.push_back(imm);
        rowMode.push_back(mode);
    endtask

    task automatic fillTable();
        addRow("or",         OP_OR,    12'h0F0, MODE_RANDOM);
        addRow("and",        OP_AND,   12'h8FF, MODE_RANDOM);
        addRow("add",        OP_ADD,   12'h7FF, MODE_RANDOM);
        addRow("mul",        OP_MUL,   12'h003, MODE_RANDOM);
        addRow("rsv4",       OP_RSV4,  12'h155, MODE_RANDOM);
        addRow("shl",        OP_SHL,   12'h004, MODE_RANDOM);
        addRow("shl big",    OP_SHL,   12'h020, MODE_BIGSHIFT);
        addRow("shr",        OP_SHR,   12'h010, MODE_RANDOM);
        addRow("shr big",    OP_SHR,   12'hFE0, MODE_BIGSHIFT);
        addRow("lt neg",     OP_LT,    12'h800, MODE_NEG);
        addRow("lt zero",    OP_LT,    12'h001, MODE_ZERO);
        addRow("eq same",    OP_EQ,    12'h000, MODE_EQUAL);
        addRow("eq",         OP_EQ,    12'h7AB, MODE_RANDOM);
        addRow("gt neg",     OP_GT,    12'hFFF, MODE_NEG);
        addRow("andn",       OP_ANDN,  12'h0AA, MODE_RANDOM);
        addRow("xor",        OP_XOR,   12'h3C3, MODE_RANDOM);
        addRow("sub neg",    OP_SUB,   12'h100, MODE_NEG);
        addRow("xnor zero",  OP_XNOR,  12'h000, MODE_ZERO);
        addRow("ne same",    OP_NE,    12'h000, MODE_EQUAL);
        addRow("rsv15",      OP_RSV15, 12'h222, MODE_RANDOM);
    endtask

    task automatic emit(input word_t w);
        imem[progLen] = w;
        progLen++;
    endtask

    task automatic expectStore(input string name, input word_t addr, input word_t data);
        expName.push_back(name);
        expAddr.push_back(addr);
        expData.push_back(data);
    endtask

    task automatic buildProgram();
        word_t x;
        word_t y;
        int    slot;
        emit(encode(0, 0, 0, 0, 0, 0, OP_OR, 12'h123));          // Write to r0 is dropped
        expectStore("r0 reads zero", STORE_ADDR, 32'h0);
        emit(encode(0, 1, 1, 0, 0, 0, OP_OR, STORE_ADDR));
        expectStore("r15 reads pc plus one", STORE_ADDR, progLen + 1);
        emit(encode(0, 1, 1, 15, 0, 0, OP_OR, STORE_ADDR));
        emit(encode(0, 0, 0, 4, 0, 0, OP_OR, 12'h0C0));
        expectStore("store without deref", 32'h0C0, 32'h5A5);
        emit(encode(0, 1, 0, 4, 0, 0, OP_OR, 12'h5A5));          // r4 is the address
        emit(encode(0, 0, 0, 15, 0, 0, OP_OR, 12'(progLen + 3)));   // Jump over two bad words
        emit(ILLEGAL);
        emit(ILLEGAL);
        expectStore("branch target pc", STORE_ADDR, progLen + 1);
        emit(encode(0, 1, 1, 15, 0, 0, OP_OR, STORE_ADDR));
        pauseAddr = progLen;
        for (int i = 0; i < rowName.size(); i++) begin
            for (int t = 0; t < 2; t++) begin
                x = nextRand();
                y = nextRand();
                case (rowMode[i])
                    MODE_ZERO:     x = '0;
                    MODE_NEG: begin
                        x = x | 32'h8000_0000;
                        y = y & 32'h7FFF_FFFF;
                    end
                    MODE_BIGSHIFT: y = 32'd32 + (y & 32'hFF);
                    MODE_EQUAL:    y = x;
                    default:       ;
                endcase
                slot = 16 + 4 * i + 2 * t;   // Operand pair in data memory
                dmem[slot]     = x;
                dmem[slot + 1] = y;
                emit(encode(0, 0, 1, 1, 0, 0, OP_OR, 12'(slot)));
                emit(encode(0, 0, 1, 2, 0, 0, OP_OR, 12'(slot + 1)));
                emit(encode(1'(t), 0, 0, 3, 1, 2, rowOp[i], rowImm[i]));
                emit(encode(0, 1, 1, 3, 0, 0, OP_OR, STORE_ADDR));
                expectStore($sformatf("%s type %0d", rowName[i], t), STORE_ADDR,
                            modelRhs(rowOp[i], 1'(t), x, y, rowImm[i]));
            end
        end
        haltAddr = progLen;
        emit(ILLEGAL);
        emit(encode(0, 1, 1, 0, 0, 0, OP_OR, STORE_ADDR));   // Must never run
    endtask

    task automatic recordStore();
        string name;
        if (expName.size() == 0) begin
            errors++;
            $display("Unexpected store to address %h with data %h", dAddr, dDataOut);
        end else begin
            name = expName.pop_front();
            checkAddr({name, " address"}, expAddr.pop_front(), dAddr);
            checkWord(name, expData.pop_front(), dDataOut);
        end
        dmem[dAddr[7:0]] = dDataOut;
    endtask

    // Called on every falling edge while the program runs
    task automatic watchCycle();
        if (dWrite) recordStore();
        if (enable) enabledCycles++;
        if (pauseLeft > 0) begin
            checkAddr("iAddr holds while disabled", pauseAddr, iAddr);
            pauseLeft--;
            if (pauseLeft == 0) enable = 1'b1;
        end
        if (iAddr !== lastAddr) begin
            if (!enable) begin
                errors++;
                $display("iAddr moved from %h to %h while enable was low", lastAddr, iAddr);
            end
            checkWord("enabled cycles per instruction", 32'd3, enabledCycles);
            enabledCycles = 0;
            lastAddr = iAddr;
            if (iAddr == pauseAddr && !pauseDone) begin
                enable = 1'b0;
                pauseLeft = 5;
                pauseDone = 1;
            end
        end
    endtask

    initial begin
        enable = 1'b0;
        for (int a = 0; a < 256; a++) begin
            dmem[a] = word_t'(a) * 32'h0001_0001 ^ 32'h5EED_0000;
        end
        fillTable();
        buildProgram();
        waitCount = 0;
        while (reset_n !== 1'b1 && waitCount < RESET_LIMIT) begin
            @(negedge clk);
            waitCount++;
        end
        if (reset_n !== 1'b1) begin
            errors++;
            $display("Timeout: reset_n was never released");
        end else begin
            checkAddr("iAddr after reset", 32'h0, iAddr);
            checkHalt("halt after reset", 1'b0, halt);
            if (dWrite !== 1'b0) begin
                errors++;
                $display("dWrite is high right after reset");
            end
            lastAddr = iAddr;
            enable = 1'b1;
            waitCount = 0;
            while (halt !== 1'b1 && waitCount < RUN_LIMIT) begin
                @(negedge clk);
                waitCount++;
                watchCycle();
            end
            if (halt !== 1'b1) begin
                errors++;
                $display("Timeout: halt never rose within %0d cycles", RUN_LIMIT);
            end else begin
                for (int i = 0; i < 6; i++) begin
                    @(negedge clk);
                    checkHalt("halt stays high", 1'b1, halt);
                    checkAddr("iAddr frozen after halt", haltAddr, iAddr);
                    if (dWrite) begin
                        errors++;
                        $display("Store issued while the core was halted");
                    end
                end
            end
            if (expName.size() != 0) begin
                errors++;
                $display("%0d expected stores never happened", expName.size());
            end
        end
        $display("Checks run: %0d, errors: %0d", checkCount, errors);
        if (errors == 0) begin
            $display("Finished with no errors");
        end else begin
            $display("Finished with errors");
        end
        $finish;
    end

endmodule

/* tenyrCore.f */
tenyrPkg.sv
decodeIf.sv
insnDecoder.sv
aluExecutor.sv
regFile.sv
tenyrCore.sv
tbClock.sv
tenyrCore_chk.sv
tenyrCore_tb.sv
